// ==== filelist.f ====
hdl/sema_pkg.sv
hdl/sema_req_if.sv
hdl/sema_bus_decode.sv
hdl/sema_counter_ram.sv
hdl/sema_resp.sv
hdl/sema_top.sv
verification/sema_clock_gen.sv
verification/sema_checker.sv
verification/sema_tb.sv

// ==== verification/sema_tb.sv ====
// Semaphore memory testbench
// Random bus accesses compared with a byte-array model of the semaphore bank
`default_nettype none

module sema_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic        clk_i;
	logic        rst_n_i;
	logic        cs_i;
	logic        cyc_i;
	logic        stb_i;
	logic        we_i;
	logic [12:0] adr_i;
	logic [7:0]  dat_i;
	logic        ack_o;
	logic [7:0]  dat_o;

	// Reference model, one byte and one written flag per semaphore
	logic [7:0]  model_mem [256];
	bit          model_written [256];
	logic [7:0]  idx_list [16];
	logic [7:0]  val_list [16];

	int seed = 32'h64cf_3fcb;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int tests_bad = 0;

	sema_clock_gen u_clk (.clk_o(clk_i));

	sema_top #(.IDX_W(8), .DATA_W(8)) dut (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .cs_i(cs_i), .cyc_i(cyc_i), .stb_i(stb_i),
		.we_i(we_i), .adr_i(adr_i), .dat_i(dat_i), .ack_o(ack_o), .dat_o(dat_o)
	);

	// ====================
	// Helpers
	// ====================

	function automatic int rand_below(int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	task automatic check_byte(string what, logic [7:0] got, logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Fail %0t: %s returned %02h, expected %02h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Counting mode saturates at 0 and 255, direct mode peeks or stores
	task automatic model_apply(input bit direct, input bit wr, input logic [7:0] idx,
			input logic [3:0] amt, input logic [7:0] wdata,
			output logic [7:0] old, output bit known);
		int v;
		known = model_written[idx];
		old = model_mem[idx];
		v = old;
		if (!direct && !wr) begin
			v = v - amt;
			if (v < 0) begin
				v = 0;
			end
		end else if (!direct && wr) begin
			v = v + amt;
			if (v > 255) begin
				v = 255;
			end
		end else if (direct && wr) begin
			v = wdata;
			model_written[idx] = 1'b1;
		end
		model_mem[idx] = v[7:0];
	endtask

	// Starts at the next falling edge, so the select was low for one sampled edge
	task automatic bus_access(input bit direct, input bit wr, input logic [7:0] idx,
			input logic [3:0] amt, input logic [7:0] wdata, output logic [7:0] rdata);
		int waited;
		bit acked;
		@(negedge clk_i);
		cs_i = 1'b1;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i = wr;
		adr_i = {direct, idx, amt};
		dat_i = wdata;
		waited = 0;
		acked = 1'b0;
		rdata = '0;
		while (!acked && waited < 20) begin
			@(negedge clk_i);
			waited++;
			if (ack_o === 1'b1) begin
				acked = 1'b1;
				rdata = dat_o;
			end
		end
		// Select stays up one more edge so ack is also seen on a rising edge
		if (acked) begin
			@(negedge clk_i);
		end
		cs_i = 1'b0;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		if (!acked) begin
			$display("No ack from the DUT within 20 cycles at %0t, semaphore %0d", $time, idx);
			errors++;
		end
	endtask

	// Old value of a never-written counter is unknown, so that return is not compared
	task automatic access_and_check(input bit direct, input bit wr, input logic [7:0] idx,
			input logic [3:0] amt, input logic [7:0] wdata, output logic [7:0] got);
		logic [7:0] exp;
		bit known;
		model_apply(direct, wr, idx, amt, wdata, exp, known);
		bus_access(direct, wr, idx, amt, wdata, got);
		if (known) begin
			checks++;
			if (got !== exp) begin
				$display("Fail %0t: sem %0d mode %0b we %0b amt %0d got %02h, expected %02h",
					$time, idx, direct, wr, amt, got, exp);
				errors++;
			end
		end
	endtask

	task automatic finish_test(string name, int err_before);
		tests++;
		if (errors == err_before) begin
			$display("Test %0d %s: ok", tests, name);
		end else begin
			tests_bad++;
			$display("Test %0d %s: %0d errors", tests, name, errors - err_before);
		end
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin
		int         err0;
		int         i;
		int         start;
		logic [7:0] idx;
		logic [7:0] got;
		logic [7:0] v;
		bit         known;
		cs_i = 1'b0;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
		adr_i = '0;
		dat_i = '0;
		rst_n_i = 1'b0;
		repeat (3) @(negedge clk_i);
		rst_n_i = 1'b1;

		// Idle bus after reset
		err0 = errors;
		for (i = 0; i < 3; i++) begin
			@(negedge clk_i);
			check_byte("idle ack_o", {7'b0, ack_o}, 8'h00);
			check_byte("idle dat_o", dat_o, 8'h00);
		end
		finish_test("idle after reset", err0);

		// Two direct writes per index, the second returns the first
		err0 = errors;
		for (i = 0; i < 8; i++) begin
			idx_list[i] = i * 32 + rand_below(32);
			access_and_check(1, 1, idx_list[i], 0, rand_below(256), got);
			val_list[i] = rand_below(256);
			access_and_check(1, 1, idx_list[i], 0, val_list[i], got);
		end
		for (i = 0; i < 8; i++) begin
			access_and_check(1, 0, idx_list[i], 0, 0, got);
			check_byte("peek after direct write", got, val_list[i]);
		end
		finish_test("direct write and peek", err0);

		// Start close to the top so twelve steps of at least 4 must saturate
		err0 = errors;
		idx = rand_below(256);
		start = 208 + rand_below(48);
		access_and_check(1, 1, idx, 0, start, got);
		repeat (12) access_and_check(0, 1, idx, 4 + rand_below(12), 0, got);
		access_and_check(1, 0, idx, 0, 0, got);
		check_byte("peek after increments", got, 8'hff);
		finish_test("counting write saturates", err0);

		// Start low so twelve steps of at least 4 must reach zero
		err0 = errors;
		idx = rand_below(256);
		start = rand_below(32);
		access_and_check(1, 1, idx, 0, start, got);
		repeat (12) access_and_check(0, 0, idx, 4 + rand_below(12), 0, got);
		access_and_check(1, 0, idx, 0, 0, got);
		check_byte("peek after decrements", got, 8'h00);
		finish_test("counting read floors", err0);

		// Sixteen indices, one per block of sixteen, then a random mix
		err0 = errors;
		for (i = 0; i < 16; i++) begin
			idx_list[i] = i * 16 + rand_below(16);
			access_and_check(1, 1, idx_list[i], 0, rand_below(256), got);
		end
		for (i = 0; i < 300; i++) begin
			access_and_check(rand_below(2), rand_below(2), idx_list[rand_below(16)],
				rand_below(16), rand_below(256), got);
		end
		finish_test("random mix", err0);

		// Select held for a single sampled edge, then dropped before ack
		err0 = errors;
		idx = idx_list[3];
		start = rand_below(200);
		access_and_check(1, 1, idx, 0, start, got);
		@(negedge clk_i);
		cs_i = 1'b1;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i = 1'b1;
		adr_i = {1'b0, idx, 4'd5};
		@(negedge clk_i);
		cs_i = 1'b0;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		model_apply(0, 1, idx, 5, 0, v, known);
		for (i = 0; i < 5; i++) begin
			@(negedge clk_i);
			check_byte("ack_o after abort", {7'b0, ack_o}, 8'h00);
			check_byte("dat_o after abort", dat_o, 8'h00);
		end
		access_and_check(1, 0, idx, 0, 0, got);
		check_byte("peek after abort", got, start + 5);
		finish_test("aborted access", err0);

		$display("Tests %0d, tests with errors %0d, checks %0d, errors %0d",
			tests, tests_bad, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule : sema_tb

`default_nettype wire

// ==== verification/sema_checker.sv ====
// Semaphore memory handshake assertions
// Bound into the top level to watch select, ack and read data
`default_nettype none

module sema_checker #(
	parameter int DATA_W = 8
) (
	input wire logic              clk_i,
	input wire logic              rst_n_i,
	input wire logic              sel_i,
	input wire logic              ack_i,
	input wire logic [DATA_W-1:0] dat_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// ====================
	// Handshake rules
	// ====================

	// Ack only shows during a select that was already high at the previous edge
	a_ack_needs_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		ack_i |-> (sel_i && $past(sel_i)))
		else $error("ack_o high without a held combined select");

	// One edge of reset is enough to clear the bus outputs
	a_reset_clears: assert property (@(posedge clk_i) !rst_n_i |=> (!ack_i && dat_i == '0))
		else $error("ack_o or dat_o not zero in the cycle after reset");

	// Edge 0 sees the rise, ack shows up in the samples of edge 3
	a_ack_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		($rose(sel_i) ##1 sel_i [*3]) |-> (ack_i && !$past(ack_i)))
		else $error("ack_o did not rise 3 cycles after a held select edge");

endmodule : sema_checker

// The combined select is taken from inside the top level
bind sema_top sema_checker #(.DATA_W(DATA_W)) u_checker (
	.clk_i  (clk_i),
	.rst_n_i(rst_n_i),
	.sel_i  (sel),
	.ack_i  (ack_o),
	.dat_i  (dat_o)
);

`default_nettype wire

// ==== verification/sema_clock_gen.sv ====
// Testbench clock source for the semaphore memory, 100 ns period
`default_nettype none

module sema_clock_gen (
	output logic clk_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// Half of the 100 ns period
	localparam int HALF_PERIOD = 50;

	initial clk_o = 1'b0;

	always #HALF_PERIOD clk_o = ~clk_o;

endmodule : sema_clock_gen

`default_nettype wire

// ==== hdl/sema_top.sv ====
// Semaphore memory top level
// Bank of counting semaphores behind a Wishbone classic slave port
`default_nettype none

module sema_top #(
	parameter  int IDX_W  = 8,
	parameter  int DATA_W = 8,
	localparam int ADR_W  = sema_pkg::SEMA_MODE_W + IDX_W + sema_pkg::SEMA_AMT_W
) (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              cs_i,
	input  logic              cyc_i,
	input  logic              stb_i,
	input  logic              we_i,
	input  logic [ADR_W-1:0]  adr_i,
	input  logic [DATA_W-1:0] dat_i,
	output logic              ack_o,
	output logic [DATA_W-1:0] dat_o
);

	// ====================
	// Stage links
	// ====================

	// Live combined select from the decode stage
	logic              sel;
	// Counter stage answer
	logic              rsp_valid;
	logic [DATA_W-1:0] rsp_data;

	sema_req_if #(.IDX_W(IDX_W), .DATA_W(DATA_W)) req ();

	// ====================
	// Stages
	// ====================

	// Stage one, select edge and address split
	sema_bus_decode #(
		.IDX_W (IDX_W),
		.DATA_W(DATA_W),
		.ADR_W (ADR_W)
	) u_decode (
		.clk_i  (clk_i),
		.rst_n_i(rst_n_i),
		.cs_i   (cs_i),
		.cyc_i  (cyc_i),
		.stb_i  (stb_i),
		.we_i   (we_i),
		.adr_i  (adr_i),
		.dat_i  (dat_i),
		.sel_o  (sel),
		.req    (req.src)
	);

	// Stage two, read-modify-write of the counter
	sema_counter_ram #(
		.IDX_W (IDX_W),
		.DATA_W(DATA_W)
	) u_counter (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.req        (req.dst),
		.rsp_valid_o(rsp_valid),
		.rsp_data_o (rsp_data)
	);

	// Stage three, ack and read data back to the master
	sema_resp #(
		.DATA_W(DATA_W)
	) u_resp (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.sel_i      (sel),
		.rsp_valid_i(rsp_valid),
		.rsp_data_i (rsp_data),
		.ack_o      (ack_o),
		.dat_o      (dat_o)
	);

endmodule : sema_top

`default_nettype wire

// ==== hdl/sema_resp.sv ====
// Semaphore response stage
// Registers the returned value and drives ack and read data to the bus
`default_nettype none

module sema_resp #(
	parameter int DATA_W = 8
) (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              sel_i,
	input  logic              rsp_valid_i,
	input  logic [DATA_W-1:0] rsp_data_i,
	output logic              ack_o,
	output logic [DATA_W-1:0] dat_o
);

	// Ack flag, set by a response and held while the select stays high
	logic              ack_q;
	// Value returned to the master
	logic [DATA_W-1:0] dat_q;
	// Select as sampled at the previous edge
	logic              sel_q;
	// Response belongs to the access that is on the bus right now
	logic              rsp_take;

	// A response that arrives just after the select went low and high again
	// belongs to an aborted access, so the select must have been held
	assign rsp_take = rsp_valid_i & sel_i & sel_q;

	// ====================
	// Ack and data registers
	// ====================

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			sel_q <= 1'b0;
			ack_q <= 1'b0;
			dat_q <= '0;
		end else begin
			sel_q <= sel_i;
			if (!sel_i) begin
				// Select gone, end of the cycle for the master
				ack_q <= 1'b0;
				dat_q <= '0;
			end else if (rsp_take) begin
				ack_q <= 1'b1;
				dat_q <= rsp_data_i;
			end
		end
	end

	// Ack drops in the same cycle the master drops the select
	assign ack_o = ack_q & sel_i;
	// Data bus reads as zero whenever this slave is not selected
	assign dat_o = sel_i ? dat_q : '0;

endmodule : sema_resp

`default_nettype wire

// ==== hdl/sema_counter_ram.sv ====
// Semaphore counter stage
// Holds the counter array and does the saturating read-modify-write
`default_nettype none

module sema_counter_ram #(
	parameter int IDX_W  = 8,
	parameter int DATA_W = 8
) (
	input  logic              clk_i,
	input  logic              rst_n_i,
	sema_req_if.dst           req,
	output logic              rsp_valid_o,
	output logic [DATA_W-1:0] rsp_data_o
);
	import sema_pkg::*;

	// Number of semaphores in the bank
	localparam int DEPTH = 2 ** IDX_W;

	// Saturation limits
	localparam logic [DATA_W-1:0] CNT_MAX = '1;
	localparam logic [DATA_W-1:0] CNT_MIN = '0;

	// ====================
	// Counter array
	// ====================

	// Counters are undefined until a direct write sets them
	logic [DATA_W-1:0] mem [DEPTH];

	// Value held before this access, read without a clock
	logic [DATA_W-1:0] old_val;
	// Amount widened by one bit so carry and borrow are visible
	logic [DATA_W:0]   amt_ext;
	// Sum and difference, top bit flags overflow or underflow
	logic [DATA_W:0]   inc_val;
	logic [DATA_W:0]   dec_val;
	// Value written back
	logic [DATA_W-1:0] new_val;

	assign old_val = mem[req.index];
	assign amt_ext = (DATA_W + 1)'(req.amount);
	assign inc_val = {1'b0, old_val} + amt_ext;
	assign dec_val = {1'b0, old_val} - amt_ext;

	// ====================
	// Next value
	// ====================

	always_comb begin
		new_val = old_val;
		case (req.op)
			SEMA_DEC: begin
				// Borrow out of the top means the count would go negative
				new_val = dec_val[DATA_W] ? CNT_MIN : dec_val[DATA_W-1:0];
			end
			SEMA_INC: begin
				// Carry out means the count would wrap, so pin it at all ones
				new_val = inc_val[DATA_W] ? CNT_MAX : inc_val[DATA_W-1:0];
			end
			SEMA_PEEK: begin
				new_val = old_val;
			end
			SEMA_SET: begin
				new_val = req.wdata;
			end
			default: begin
				new_val = old_val;
			end
		endcase
	end

	// The whole update lands in one edge, so a request two cycles later
	// to the same semaphore already sees this result
	always_ff @(posedge clk_i) begin
		if (req.valid) begin
			mem[req.index] <= new_val;
		end
	end

	// ====================
	// Response
	// ====================

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= req.valid;
		end
	end

	// Every access answers with the value from before the update
	always_ff @(posedge clk_i) begin
		if (req.valid) begin
			rsp_data_o <= old_val;
		end
	end

endmodule : sema_counter_ram

`default_nettype wire

// ==== hdl/sema_bus_decode.sv ====
// Semaphore bus decode stage
// Detects a new bus access on the select edge and registers one request
`default_nettype none

module sema_bus_decode #(
	parameter int IDX_W  = 8,
	parameter int DATA_W = 8,
	parameter int ADR_W  = sema_pkg::SEMA_MODE_W + IDX_W + sema_pkg::SEMA_AMT_W
) (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              cs_i,
	input  logic              cyc_i,
	input  logic              stb_i,
	input  logic              we_i,
	input  logic [ADR_W-1:0]  adr_i,
	input  logic [DATA_W-1:0] dat_i,
	output logic              sel_o,
	sema_req_if.src           req
);
	import sema_pkg::*;

	// ====================
	// Select edge
	// ====================

	// Combined select, all three bus qualifiers at once
	logic sel;
	// Select as sampled at the previous edge
	logic sel_q;
	// High for the one cycle where a new access begins
	logic sel_rise;

	assign sel      = cs_i & cyc_i & stb_i;
	assign sel_rise = sel & ~sel_q;

	// The response stage needs the live select to gate ack and data
	assign sel_o = sel;

	// After reset the select counts as previously low, so a select that is
	// already high on the first edge still starts an access
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			sel_q     <= 1'b0;
			req.valid <= 1'b0;
		end else begin
			sel_q     <= sel;
			// Exactly one request per rising edge of the select
			req.valid <= sel_rise;
		end
	end

	// ====================
	// Request fields
	// ====================

	// Fields are only loaded on the edge and hold until the next access
	always_ff @(posedge clk_i) begin
		if (sel_rise) begin
			// Top address bit picks the mode, we_i picks the direction
			req.op     <= sema_op_e'({adr_i[ADR_W-1], we_i});
			// Index sits just above the amount field
			req.index  <= adr_i[SEMA_AMT_W +: IDX_W];
			req.amount <= adr_i[SEMA_AMT_W-1:0];
			req.wdata  <= dat_i;
		end
	end

endmodule : sema_bus_decode

`default_nettype wire

// ==== hdl/sema_req_if.sv ====
// Semaphore request link
// Carries one decoded request from the decode stage to the counter stage
`default_nettype none

interface sema_req_if #(
	parameter int IDX_W  = 8,
	parameter int DATA_W = 8
);
	import sema_pkg::*;

	// One-cycle pulse, no back-pressure on this path
	logic                  valid;
	// Operation decoded from mode bit and write enable
	sema_op_e              op;
	// Semaphore selected by the address
	logic [IDX_W-1:0]      index;
	// Step for counting accesses
	logic [SEMA_AMT_W-1:0] amount;
	// Data byte for direct writes
	logic [DATA_W-1:0]     wdata;

	// Decode side drives everything
	modport src (output valid, op, index, amount, wdata);

	// Counter side only listens
	modport dst (input valid, op, index, amount, wdata);

endinterface : sema_req_if

`default_nettype wire

// ==== hdl/sema_pkg.sv ====
// Semaphore memory shared definitions
// Operation encoding and the fixed fields of the semaphore address
`default_nettype none

package sema_pkg;

	// ====================
	// Address fields
	// ====================

	// The address is {mode, index, amount}, and the index width is a module parameter
	// Mode field width, one bit that picks counting or direct access
	localparam int SEMA_MODE_W = 1;

	// Amount field width for counting accesses
	localparam int SEMA_AMT_W = 4;

	// ====================
	// Operations
	// ====================

	// The encoding is {mode bit, write enable}, so the decode stage can
	// cast the two bus bits straight into an operation
	typedef enum logic [1:0] {
		// Counting read, decrement by amount and floor at zero
		SEMA_DEC  = 2'b00,
		// Counting write, increment by amount and cap at all ones
		SEMA_INC  = 2'b01,
		// Direct read, value stays as it is
		SEMA_PEEK = 2'b10,
		// Direct write, value takes the data byte
		SEMA_SET  = 2'b11
	} sema_op_e;

endpackage : sema_pkg

`default_nettype wire
